//--- build.f
common/div_pkg.sv
rtl/div_fifo.sv
div_unit/div_core.sv
div_unit/div_unit.sv
rtl/div_top.sv
test/div_assert.sv
test/div_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the divide unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module div_tb -Mdir obj_dir -f build.f

# The log decides the outcome; a crashed run has no pass line
./obj_dir/Vdiv_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log || ! grep -q "Test passed" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
echo "Simulation finished cleanly"

//--- test/div_tb.sv
/*
 * Directed testbench for div_top at XLEN 32, ID width 3, queue depth 2.
 * Inputs change on the falling edge; a monitor samples results mid-cycle.
 * Stops at the first mismatch or timeout.
 */
`timescale 1ns/10ps

module div_tb;
    import div_pkg::*;

    localparam int XLEN = 32;
    localparam int CLK_PERIOD = 20;
    localparam int RESULT_TIMEOUT = 4 * XLEN;    // Cycles allowed per result
    localparam int HOLD_CYCLES = XLEN + 8;       // Long enough for the next divide to stall

    logic clk, rst, new_request, reuse_result, accepted;
    logic ready, done_next_cycle;
    logic [XLEN-1:0] rs1, rs2, rd;
    logic [2:0] id, instruction_id, next_tag;
    div_op_t op;
    logic [15:0] lfsr_state;
    logic rd_pending;                            // Result lands in rd next cycle
    logic [XLEN-1:0] rd_q[$];
    logic [2:0] id_q[$];

    div_top dut_i (
        .clk(clk), .rst(rst), .new_request(new_request), .rs1(rs1), .rs2(rs2),
        .op(op), .reuse_result(reuse_result), .id(id), .accepted(accepted),
        .ready(ready), .done_next_cycle(done_next_cycle), .rd(rd),
        .instruction_id(instruction_id)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Result monitor, samples a quarter period after the falling edge
    initial begin
        rd_pending = 1'b0;
        forever begin
            @(negedge clk);
            #(CLK_PERIOD / 4);
            if (rd_pending)
                rd_q.push_back(rd);              // rd valid the cycle after done
            rd_pending = !rst && (done_next_cycle === 1'b1);
            if (rd_pending)
                id_q.push_back(instruction_id);  // Tag valid with done
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic [31:0] rand_bits(input int count);
        logic [31:0] value;
        logic feedback;
        value = '0;
        for (int i = 0; i < count; i++) begin
            feedback = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], feedback};
            value = {value[30:0], feedback};
        end
        return value;
    endfunction

    // RISC-V M extension divide semantics
    function automatic logic [31:0] ref_div(input logic [31:0] a, input logic [31:0] b,
                                            input div_op_t o);
        logic overflow;
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic [31:0] quo;
        logic [31:0] rem;
        overflow = (a == 32'h8000_0000) && (b == 32'hFFFF_FFFF);
        sa = a;
        sb = b;
        if (b == 0) begin
            quo = 32'hFFFF_FFFF;                 // All ones, remainder is dividend
            rem = a;
        end else if (o == DIVU || o == REMU) begin
            quo = a / b;
            rem = a % b;
        end else if (overflow) begin
            quo = a;                             // Most negative over minus one
            rem = 32'h0;
        end else begin
            quo = sa / sb;                       // Truncates toward zero
            rem = sa % sb;                       // Sign follows dividend
        end
        return (o == REM || o == REMU) ? rem : quo;
    endfunction

    task automatic fail_now(input string reason);
        $display("%s at time %0t", reason, $time);
        $display("Test failed");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("FAILED at time %0t: %s is %h, expected %h", $time, name, got, expected);
            $display("Test failed");
            $fatal(1, "Stopped at first error");
        end
    endtask

    task automatic push_request(input logic [31:0] a, input logic [31:0] b, input div_op_t o,
                                input logic reuse, input logic [2:0] tag);
        if (ready !== 1'b1) begin
            fail_now("Request queue full when a request was due");
        end else begin
            new_request = 1'b1;
            rs1 = a;
            rs2 = b;
            op = o;
            reuse_result = reuse;
            id = tag;
            @(negedge clk);
            new_request = 1'b0;                  // Single-cycle strobe
        end
    endtask

    task automatic get_result(input logic [31:0] exp_rd, input logic [2:0] exp_id,
                              input int limit, input string what);
        int waited;
        waited = 0;
        while (rd_q.size() == 0 && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (rd_q.size() == 0) begin
            fail_now($sformatf("No %s result within %0d cycles", what, limit));
        end else begin
            check_value({what, " rd"}, rd_q.pop_front(), exp_rd);
            check_value({what, " instruction_id"}, 32'(id_q.pop_front()), 32'(exp_id));
        end
    endtask

    task automatic release_result;
        accepted = 1'b1;                         // Frees writeback at the next edge
        @(negedge clk);
        accepted = 1'b0;
    endtask

    task automatic run_op(input logic [31:0] a, input logic [31:0] b, input div_op_t o,
                          input logic [31:0] expected);
        logic [2:0] tag;
        tag = next_tag;
        next_tag = next_tag + 1'b1;
        push_request(a, b, o, 1'b0, tag);
        get_result(expected, tag, RESULT_TIMEOUT, o.name());
        release_result();
    endtask

    task automatic test_reset_state;
        check_value("ready", 32'(ready), 32'd1);
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            check_value("done_next_cycle", 32'(done_next_cycle), 32'd0);
        end
        check_value("results seen after reset", 32'(rd_q.size()), 32'd0);
    endtask

    task automatic test_basic_ops;
        logic [31:0] pair_a[5];
        logic [31:0] pair_b[5];
        div_op_t o;
        pair_a = '{32'd100, -32'd100, 32'd100, -32'd100, 32'hFFFF_FFF0};
        pair_b = '{32'd7, 32'd7, -32'd7, -32'd7, 32'd3};
        for (int k = 0; k < 4; k++) begin
            o = div_op_t'(2'(k));
            for (int p = 0; p < 5; p++)
                run_op(pair_a[p], pair_b[p], o, ref_div(pair_a[p], pair_b[p], o));
        end
    endtask

    task automatic test_corner_cases;
        run_op(32'h1234_5678, 32'h0, DIV, 32'hFFFF_FFFF);      // Divide by zero
        run_op(32'h8765_4321, 32'h0, DIVU, 32'hFFFF_FFFF);
        run_op(32'h8765_4321, 32'h0, REM, 32'h8765_4321);
        run_op(32'h1234_5678, 32'h0, REMU, 32'h1234_5678);
        run_op(32'h8000_0000, 32'hFFFF_FFFF, DIV, 32'h8000_0000);  // Signed overflow
        run_op(32'h8000_0000, 32'hFFFF_FFFF, REM, 32'h0);
        run_op(32'h8000_0000, 32'hFFFF_FFFF, DIVU, 32'h0);
    endtask

    task automatic test_random_ops;
        logic [31:0] a, b;
        logic [1:0] op_bits;
        for (int i = 0; i < 60; i++) begin
            a = rand_bits(32);
            b = rand_bits(32);
            if (rand_bits(2) == 0)
                b = b >> 24;                     // Small divisors now and then
            op_bits = 2'(rand_bits(2));
            run_op(a, b, div_op_t'(op_bits), ref_div(a, b, div_op_t'(op_bits)));
        end
    endtask

    task automatic test_reuse;
        logic [31:0] a, b;
        logic [2:0] tag_div, tag_rem;
        a = -32'd12345;
        b = 32'd97;
        tag_div = next_tag;
        tag_rem = next_tag + 3'd1;
        next_tag = next_tag + 3'd2;
        push_request(a, b, DIV, 1'b0, tag_div);
        push_request(a, b, REM, 1'b1, tag_rem);  // Same operands, no new divide
        get_result(ref_div(a, b, DIV), tag_div, RESULT_TIMEOUT, "reuse DIV");
        release_result();
        get_result(ref_div(a, b, REM), tag_rem, XLEN, "reuse REM");
        release_result();
    endtask

    task automatic test_back_pressure;
        logic [31:0] exp_rd[8];
        logic [2:0] tags[8];
        logic [31:0] a, b;
        div_op_t o;
        int pushed;
        pushed = 0;
        while (ready === 1'b1 && pushed < 8) begin
            a = 32'd1000 + 32'(pushed * 37);
            b = 32'd3 + 32'(pushed);
            o = (pushed % 2 == 0) ? DIVU : REM;
            exp_rd[pushed] = ref_div(a, b, o);
            tags[pushed] = next_tag;
            next_tag = next_tag + 1'b1;
            push_request(a, b, o, 1'b0, tags[pushed]);
            pushed++;
        end
        if (ready !== 1'b0) begin
            fail_now("ready never fell while filling the queue");
        end else begin
            for (int i = 0; i < pushed; i++) begin
                get_result(exp_rd[i], tags[i], RESULT_TIMEOUT, "back-pressure");
                for (int h = 0; h < HOLD_CYCLES; h++) begin
                    @(negedge clk);
                    check_value("rd while held", rd, exp_rd[i]);
                    check_value("results during hold", 32'(rd_q.size()), 32'd0);
                end
                release_result();
            end
        end
    endtask

    initial begin
        rst = 1'b1;
        new_request = 1'b0;
        rs1 = '0;
        rs2 = '0;
        op = DIV;
        reuse_result = 1'b0;
        id = '0;
        accepted = 1'b0;
        next_tag = '0;
        lfsr_state = 16'd37;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        test_reset_state();
        test_basic_ops();
        test_corner_cases();
        test_reuse();
        test_random_ops();
        test_back_pressure();
        $display("Test passed");
        $finish;
    end

endmodule

//--- test/div_assert.sv
/*
 * Handshake checks for the divide unit, bound into div_unit.
 * Assumes the core side obeys ready and only accepts held results.
 * held is the internal writeback-occupied flag of div_unit.
 */
`timescale 1ns/10ps

module div_assert (
    input logic clk,
    input logic rst,
    input logic new_request,
    input logic ready,
    input logic accepted,
    input logic held,
    input logic done_next_cycle
);

    accept_needs_result: assert property (@(posedge clk) disable iff (rst)
        accepted |-> held)
        else $error("accepted strobe while no result was held");

    request_needs_ready: assert property (@(posedge clk) disable iff (rst)
        new_request |-> ready)
        else $error("new_request strobe while the queue was full");

    done_is_pulse: assert property (@(posedge clk) disable iff (rst)
        !(done_next_cycle && $past(done_next_cycle)))
        else $error("done_next_cycle high for two cycles in a row");

endmodule

bind div_unit div_assert div_assert_i (
    .clk(clk),
    .rst(rst),
    .new_request(new_request),
    .ready(ready),
    .accepted(accepted),
    .held(held),
    .done_next_cycle(done_next_cycle)
);

//--- rtl/div_top.sv
/*
 * Top level of the divide execution unit.
 * Fixes the sizes from the package defaults and brings every port out.
 * Adds no pipeline stages.
 */
`timescale 1ns/10ps

module div_top #(
    parameter int XLEN       = div_pkg::DEFAULT_XLEN,
    parameter int ID_WIDTH   = div_pkg::DEFAULT_ID_WIDTH,
    parameter int FIFO_DEPTH = div_pkg::DEFAULT_FIFO_DEPTH
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  new_request,
    input  logic [XLEN-1:0]       rs1,
    input  logic [XLEN-1:0]       rs2,
    input  div_pkg::div_op_t      op,
    input  logic                  reuse_result,
    input  logic [ID_WIDTH-1:0]   id,
    input  logic                  accepted,
    output logic                  ready,
    output logic                  done_next_cycle,
    output logic [XLEN-1:0]       rd,
    output logic [ID_WIDTH-1:0]   instruction_id
);

    div_unit #(
        .XLEN(XLEN),
        .ID_WIDTH(ID_WIDTH),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) div_unit_i (
        .clk(clk),
        .rst(rst),
        .new_request(new_request),
        .rs1(rs1),
        .rs2(rs2),
        .op(op),
        .reuse_result(reuse_result),
        .id(id),
        .accepted(accepted),
        .ready(ready),
        .done_next_cycle(done_next_cycle),
        .rd(rd),
        .instruction_id(instruction_id)
    );

endmodule

//--- div_unit/div_unit.sv
/*
 * Integer divide unit: request queue, sign handling, divider, writeback.
 * Core must strobe new_request only while ready is high, and accepted
 * only while a result is held. No flush or abort support.
 * reuse_result is only valid right after a divide on the same operands,
 * since it takes q/r straight from the idle divider.
 */
`timescale 1ns/10ps

module div_unit #(
    parameter int XLEN       = div_pkg::DEFAULT_XLEN,
    parameter int ID_WIDTH   = div_pkg::DEFAULT_ID_WIDTH,
    parameter int FIFO_DEPTH = div_pkg::DEFAULT_FIFO_DEPTH
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  new_request,
    input  logic [XLEN-1:0]       rs1,
    input  logic [XLEN-1:0]       rs2,
    input  div_pkg::div_op_t      op,
    input  logic                  reuse_result,
    input  logic [ID_WIDTH-1:0]   id,
    input  logic                  accepted,
    output logic                  ready,
    output logic                  done_next_cycle,
    output logic [XLEN-1:0]       rd,
    output logic [ID_WIDTH-1:0]   instruction_id
);
    import div_pkg::*;

    localparam int OP_W    = $bits(div_op_t);
    localparam int ENTRY_W = 2 * XLEN + OP_W + 1 + ID_WIDTH;

    logic [ENTRY_W-1:0]  entry_in;
    logic [ENTRY_W-1:0]  entry_out;
    logic                head_valid;
    logic                fifo_full;
    logic                finish;         // Result written back this cycle

    logic [XLEN-1:0]     head_rs1;
    logic [XLEN-1:0]     head_rs2;
    div_op_t             head_op;
    logic                head_reuse;
    logic [ID_WIDTH-1:0] head_id;

    logic                signed_op;
    logic                rem_op;
    logic                neg_a;          // Dividend magnitude needs negation
    logic                neg_b;
    logic [XLEN-1:0]     mag_a;
    logic [XLEN-1:0]     mag_b;

    logic                start;
    logic                in_progress;    // Divide issued for the head entry
    logic                core_complete;
    logic                core_ack;
    logic [XLEN-1:0]     quotient;
    logic [XLEN-1:0]     remainder;
    logic                divisor_zero;

    logic                held;           // rd holds an unaccepted result
    logic                wb_free;
    logic                negate_result;
    logic [XLEN-1:0]     raw_result;
    logic [XLEN-1:0]     result;

    // Request queue
    assign entry_in = {rs1, rs2, op, reuse_result, id};

    div_fifo #(.WIDTH(ENTRY_W), .DEPTH(FIFO_DEPTH)) req_fifo_i (
        .clk(clk), .rst(rst), .push(new_request), .pop(finish), .data_in(entry_in),
        .data_out(entry_out), .valid(head_valid), .full(fifo_full)
    );

    assign ready      = ~fifo_full;
    assign head_rs1   = entry_out[ENTRY_W-1 -: XLEN];
    assign head_rs2   = entry_out[ENTRY_W-XLEN-1 -: XLEN];
    assign head_op    = div_op_t'(entry_out[ID_WIDTH+1 +: OP_W]);
    assign head_reuse = entry_out[ID_WIDTH];
    assign head_id    = entry_out[ID_WIDTH-1:0];

    // Operand magnitudes
    assign signed_op = (head_op == DIV) || (head_op == REM);
    assign rem_op    = (head_op == REM) || (head_op == REMU);
    assign neg_a     = signed_op & head_rs1[XLEN-1];
    assign neg_b     = signed_op & head_rs2[XLEN-1];
    assign mag_a     = (neg_a ? ~head_rs1 : head_rs1) + XLEN'(neg_a);
    assign mag_b     = (neg_b ? ~head_rs2 : head_rs2) + XLEN'(neg_b);

    // Issue and completion
    assign wb_free  = ~held | accepted;                  // Slot frees this edge
    assign start    = head_valid & ~in_progress & ~head_reuse;
    assign core_ack = core_complete & wb_free;
    assign finish   = (core_complete | (head_valid & head_reuse)) & wb_free;

    always_ff @(posedge clk) begin
        if (rst)
            in_progress <= 1'b0;
        else if (start)
            in_progress <= 1'b1;
        else if (core_ack)
            in_progress <= 1'b0;                         // Head pops same edge
    end

    div_core #(.XLEN(XLEN)) core_i (
        .clk(clk), .rst(rst), .start(start), .ack(core_ack), .a(mag_a), .b(mag_b),
        .q(quotient), .r(remainder), .complete(core_complete), .b_is_zero(divisor_zero)
    );

    // Sign correction; remainder follows dividend, quotient kept on /0
    always_comb begin
        if (rem_op) begin
            raw_result    = remainder;
            negate_result = neg_a;
        end else begin
            raw_result    = quotient;
            negate_result = ~divisor_zero & (neg_a ^ neg_b);
        end
        result = (negate_result ? ~raw_result : raw_result) + XLEN'(negate_result);
    end

    // Writeback register
    always_ff @(posedge clk) begin
        if (finish)
            rd <= result;
    end

    always_ff @(posedge clk) begin
        if (rst)
            held <= 1'b0;
        else if (finish)
            held <= 1'b1;                                // New result replaces accepted one
        else if (accepted)
            held <= 1'b0;
    end

    assign done_next_cycle = finish;
    assign instruction_id  = head_id;                    // Valid with done_next_cycle

endmodule

//--- div_unit/div_core.sv
/*
 * Radix-2 restoring divider on unsigned operands.
 * start is a single-cycle pulse; complete rises XLEN+1 cycles later
 * and stays high until ack. q and r hold until the next start.
 * Divide by zero yields q all ones and r = a, as RISC-V expects.
 * XLEN must be at least 8.
 */
`timescale 1ns/10ps

module div_core #(
    parameter int XLEN = div_pkg::DEFAULT_XLEN
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            start,
    input  logic            ack,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic [XLEN-1:0] q,
    output logic [XLEN-1:0] r,
    output logic            complete,
    output logic            b_is_zero
);
    localparam int CNT_W = $clog2(XLEN);

    logic [XLEN-1:0]  divisor;           // Latched b
    logic [CNT_W-1:0] step_cnt;          // Iteration index
    logic             running;           // Steps in flight
    logic             last_step;
    logic [XLEN:0]    shifted;           // Remainder with next dividend bit in
    logic [XLEN+1:0]  trial;             // Trial subtraction, sign on top
    logic             fits;              // Divisor goes into shifted

    assign shifted   = {r, q[XLEN-1]};
    assign trial     = {1'b0, shifted} - {2'b00, divisor};
    assign fits      = ~trial[XLEN+1];
    assign last_step = running && (step_cnt == CNT_W'(XLEN - 1));

    // Control state
    always_ff @(posedge clk) begin
        if (rst) begin
            running  <= 1'b0;
            complete <= 1'b0;
        end else if (start) begin
            running  <= 1'b1;
            complete <= 1'b0;            // Drop any stale result flag
        end else if (last_step) begin
            running  <= 1'b0;
            complete <= 1'b1;
        end else if (ack) begin
            complete <= 1'b0;
        end
    end

    // Datapath, one quotient bit per cycle
    always_ff @(posedge clk) begin
        if (start) begin
            q         <= a;              // Dividend shifts out as quotient shifts in
            r         <= '0;
            divisor   <= b;
            b_is_zero <= (b == '0);
            step_cnt  <= '0;
        end else if (running) begin
            step_cnt <= step_cnt + 1'b1;
            q        <= {q[XLEN-2:0], fits};
            // Restore on miss; top bit of shifted is zero then
            r        <= fits ? trial[XLEN-1:0] : shifted[XLEN-1:0];
        end
    end

endmodule

//--- rtl/div_fifo.sv
/*
 * First-word-fall-through request queue.
 * Head entry appears on data_out one cycle after its push.
 * Push while full and pop while empty are dropped, not flagged here.
 * Storage has no reset; only pointers and count are cleared.
 */
`timescale 1ns/10ps

module div_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 2
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             push,
    input  logic             pop,
    input  logic [WIDTH-1:0] data_in,
    output logic [WIDTH-1:0] data_out,
    output logic             valid,
    output logic             full
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];       // Entry storage
    logic [PTR_W-1:0] rd_ptr;            // Head slot
    logic [PTR_W-1:0] wr_ptr;            // Next free slot
    logic [CNT_W-1:0] count;             // Occupied entries
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;   // Wrap at DEPTH
    endfunction

    assign do_push = push & ~full;       // Overflow dropped
    assign do_pop  = pop & valid;        // Underflow dropped

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)
                rd_ptr <= next_ptr(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;     // Idle or push+pop together
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= data_in;
    end

    assign data_out = mem[rd_ptr];       // Fall-through head
    assign valid    = (count != '0);
    assign full     = (count == CNT_W'(DEPTH));

endmodule

//--- common/div_pkg.sv
/*
 * Shared definitions for the divide execution unit.
 * The operation encoding mirrors funct3[1:0] of the RISC-V M extension.
 * Sizes here are defaults only; the top level passes the real values down.
 */

package div_pkg;

    // Bit 0 selects unsigned, bit 1 selects remainder
    typedef enum logic [1:0] {
        DIV  = 2'd0,    // Signed quotient
        DIVU = 2'd1,    // Unsigned quotient
        REM  = 2'd2,    // Signed remainder
        REMU = 2'd3     // Unsigned remainder
    } div_op_t;

    // Operand width, must be at least 8
    localparam int DEFAULT_XLEN = 32;

    // Instruction tag carried alongside each request
    localparam int DEFAULT_ID_WIDTH = 3;

    // Request queue entries, at least 1
    localparam int DEFAULT_FIFO_DEPTH = 2;

endpackage
